// File: cpu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the multicycle core: widths, opcode and funct codes,
// instruction field layout and the decoded control word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cpu_pkg;

    typedef logic [15:0] word_t;     // Register value, data address, pc
    typedef logic [31:0] instr_t;    // Raw instruction word
    typedef logic [3:0]  reg_idx_t;  // One of 16 registers

    typedef enum logic [5:0] {
        op_r_type  = 6'h00,          // Operation selected by funct
        op_load    = 6'h01,
        op_store   = 6'h02,
        op_j       = 6'h03,          // Absolute jump to imm
        op_jal     = 6'h04,          // Link to r15, jump to rs
        op_beq     = 6'h05,
        op_bne     = 6'h06,
        op_jt      = 6'h07,          // Branch on true flag
        op_jf      = 6'h08,          // Branch on true flag clear
        op_loadlit = 6'h09,
        op_addi    = 6'h0a,
        op_andi    = 6'h0b,
        op_ori     = 6'h0c,
        op_slti    = 6'h0d
    } opcode_e;

    typedef enum logic [5:0] {
        fn_jr  = 6'h08,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a               // Signed compare
    } funct_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } fsm_state_e;

    typedef enum logic [1:0] {
        wb_alu,                      // ALU result
        wb_mem,                      // Data memory read
        wb_pc,                       // Return address for jal
        wb_imm                       // Literal for loadlit
    } wb_sel_e;

    typedef enum logic [1:0] {
        dst_rt,
        dst_rd,
        dst_r15                      // Link register
    } reg_dst_e;

    // rd overlays imm[15:12], funct overlays imm[5:0]
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [1:0] spare;
        word_t      imm;
    } instr_fields_t;

    typedef struct packed {
        funct_e   alu_funct;         // ALU operation
        logic     alu_src_imm;       // Operand b from imm
        logic     jump_src_reg;      // Jump target from rs (jr, jal)
        reg_dst_e reg_dst;
        logic     is_jump;
        logic     is_branch;
        logic     test_true;         // Branch tests true flag, not zero
        logic     sel_bne;           // Invert zero test
        logic     sel_jf;            // Invert true test
        logic     mem_write;
        logic     mem_read;
        logic     flag_write;
        logic     reg_write;
        wb_sel_e  wb_sel;
    } ctrl_t;

endpackage

`default_nettype wire

// File: control_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decoder. Turns the latched opcode and funct into the control
// levels that steer the datapath and the cycle sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module control_unit import cpu_pkg::*; (
    input  opcode_e opcode,          // From instruction register
    input  funct_e  funct,           // R-type operation field
    output ctrl_t   ctrl
);

    always_comb begin
        // Safe defaults, nothing written, no control transfer
        ctrl.alu_funct    = fn_add;
        ctrl.alu_src_imm  = 1'b1;    // Immediate operand
        ctrl.jump_src_reg = 1'b0;
        ctrl.reg_dst      = dst_rt;
        ctrl.is_jump      = 1'b0;
        ctrl.is_branch    = 1'b0;
        ctrl.test_true    = 1'b0;
        ctrl.sel_bne      = 1'b0;
        ctrl.sel_jf       = 1'b0;
        ctrl.mem_write    = 1'b0;
        ctrl.mem_read     = 1'b0;
        ctrl.flag_write   = 1'b0;
        ctrl.reg_write    = 1'b0;
        ctrl.wb_sel       = wb_alu;

        case (opcode)
            op_store: begin
                ctrl.mem_write = 1'b1;           // Address rs+imm, data rt
            end
            op_load: begin
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_mem;
            end
            op_j: begin
                ctrl.is_jump = 1'b1;             // Target is imm
            end
            op_jal: begin
                ctrl.is_jump      = 1'b1;
                ctrl.jump_src_reg = 1'b1;        // Target is rs
                ctrl.reg_dst      = dst_r15;
                ctrl.reg_write    = 1'b1;
                ctrl.wb_sel       = wb_pc;       // Return address into r15
            end
            op_beq: ctrl.is_branch = 1'b1;
            op_bne: begin
                ctrl.is_branch = 1'b1;
                ctrl.sel_bne   = 1'b1;
            end
            op_jt: begin
                ctrl.is_branch = 1'b1;
                ctrl.test_true = 1'b1;
            end
            op_jf: begin
                ctrl.is_branch = 1'b1;
                ctrl.test_true = 1'b1;
                ctrl.sel_jf    = 1'b1;
            end
            op_loadlit: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_imm;
            end
            op_r_type: begin
                ctrl.reg_dst     = dst_rd;
                ctrl.alu_src_imm = 1'b0;         // Second operand is rt
                case (funct)
                    fn_jr: begin
                        ctrl.is_jump      = 1'b1;
                        ctrl.jump_src_reg = 1'b1;
                    end
                    fn_add, fn_sub, fn_and, fn_or, fn_slt: begin
                        ctrl.alu_funct  = funct;
                        ctrl.reg_write  = 1'b1;
                        ctrl.flag_write = 1'b1;
                    end
                    default: ;                   // Unknown funct runs as a no-op
                endcase
            end
            op_addi, op_andi, op_ori, op_slti: begin
                ctrl.reg_write  = 1'b1;
                ctrl.flag_write = 1'b1;
                case (opcode)
                    op_andi: ctrl.alu_funct = fn_and;
                    op_ori:  ctrl.alu_funct = fn_or;
                    op_slti: ctrl.alu_funct = fn_slt;
                    default: ctrl.alu_funct = fn_add;
                endcase
            end
            default: ;                           // Unknown opcode, no-op
        endcase
    end

endmodule

`default_nettype wire

// File: cycle_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction phase sequencer. Walks fetch, decode, execute, memory and
// writeback and issues one-cycle strobes gated by the decoded controls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module cycle_fsm import cpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  ctrl_t ctrl,              // Valid from execute on
    output logic  ir_load,
    output logic  pc_step,
    output logic  pc_redirect_en,
    output logic  flag_en,
    output logic  mem_we,
    output logic  mem_re,
    output logic  reg_we
);

    fsm_state_e state;
    fsm_state_e state_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_fetch;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = st_fetch;
        case (state)
            st_fetch:  state_next = st_decode;   // imem read in flight
            st_decode: state_next = st_execute;
            st_execute: begin
                if (ctrl.mem_write || ctrl.mem_read) begin
                    state_next = st_memory;
                end else if (ctrl.reg_write) begin
                    state_next = st_writeback;   // ALU ops, loadlit, jal
                end else begin
                    state_next = st_fetch;       // Jumps, branches, jr
                end
            end
            st_memory: state_next = ctrl.mem_read ? st_writeback : st_fetch;
            st_writeback: state_next = st_fetch;
            default: state_next = st_fetch;
        endcase
    end

    // Strobes only in their own phase
    assign ir_load        = (state == st_decode);
    assign pc_step        = (state == st_decode);
    assign pc_redirect_en = (state == st_execute) && (ctrl.is_jump || ctrl.is_branch);
    assign flag_en        = (state == st_execute) && ctrl.flag_write;
    assign mem_we         = (state == st_memory) && ctrl.mem_write;
    assign mem_re         = (state == st_memory) && ctrl.mem_read;
    assign reg_we         = (state == st_writeback) && ctrl.reg_write;

endmodule

`default_nettype wire

// File: program_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program counter. Steps in decode and is redirected in execute by jumps
// and taken branches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module program_counter import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0   // Address of first instruction
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  step,              // pc+1 in decode
    input  logic  redirect_en,       // Execute phase of a jump or branch
    input  logic  is_jump,
    input  logic  jump_src_reg,
    input  logic  take_branch,
    input  word_t imm,
    input  word_t rs_data,
    output word_t pc
);

    word_t jump_target;

    assign jump_target = jump_src_reg ? rs_data : imm;  // jr/jal use rs

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (step) begin
            pc <= pc + word_t'(1);
        end else if (redirect_en && is_jump) begin
            pc <= jump_target;
        end else if (redirect_en && take_branch) begin
            pc <= pc + imm;          // Relative to pc+1, already stepped
        end
    end

endmodule

`default_nettype wire

// File: register_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16 x 16 register file, two asynchronous read ports, one clocked write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  reg_idx_t wr_idx,
    input  logic     we,             // Writeback strobe
    input  word_t    wdata,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [16];                // r0 is writable like the rest

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_idx] <= wdata;
        end
    end

    assign rs_data = regs[rs_idx];   // Old value on same-cycle write
    assign rt_data = regs[rt_idx];

endmodule

`default_nettype wire

// File: alu_flags.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU with zero and true flag registers. The flags set in one instruction
// decide the branches that follow it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module alu_flags import cpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  ctrl_t ctrl,
    input  logic  flag_en,           // Execute phase of a flag writer
    input  word_t a,                 // rs
    input  word_t b_reg,             // rt
    input  word_t imm,
    output word_t result,
    output logic  take_branch
);

    word_t b;
    logic  zero_flag;
    logic  true_flag;
    logic  flag_test;

    // imm already spans the full word, so sign extension is a no-op here
    assign b = ctrl.alu_src_imm ? imm : b_reg;

    always_comb begin
        case (ctrl.alu_funct)
            fn_sub:  result = a - b;
            fn_and:  result = a & b;
            fn_or:   result = a | b;
            fn_slt:  result = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            default: result = a + b;  // add, addi, address calc
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            zero_flag <= 1'b0;
            true_flag <= 1'b0;
        end else if (flag_en) begin
            zero_flag <= (result == '0);
            true_flag <= result[0];   // slt leaves 1 or 0 here
        end
    end

    // beq/bne look at zero, jt/jf at true; bne and jf invert
    always_comb begin
        if (ctrl.test_true) begin
            flag_test = true_flag ^ ctrl.sel_jf;
        end else begin
            flag_test = zero_flag ^ ctrl.sel_bne;
        end
    end

    assign take_branch = ctrl.is_branch && flag_test;

endmodule

`default_nettype wire

// File: cpu_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multicycle core top. Holds the instruction register and writeback muxes
// and connects the blocks to the external instruction and data memories
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module cpu_core import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic   clk,
    input  logic   arst_n,
    output word_t  imem_addr,        // Word returned next cycle
    input  instr_t imem_rdata,
    output word_t  dmem_addr,
    output word_t  dmem_wdata,
    output logic   dmem_we,          // One-cycle strobe
    output logic   dmem_re,          // rdata valid next cycle
    input  word_t  dmem_rdata
);

    instr_t        ir;
    instr_fields_t ir_fields;
    word_t         link_pc;          // pc+1 of the current instruction
    ctrl_t         ctrl;
    word_t         pc;
    word_t         rs_data;
    word_t         rt_data;
    word_t         alu_result;
    word_t         wb_data;
    reg_idx_t      wr_idx;
    logic          take_branch;
    logic          ir_load;
    logic          pc_step;
    logic          pc_redirect_en;
    logic          flag_en;
    logic          mem_we;
    logic          mem_re;
    logic          reg_we;

    always_ff @(posedge clk) begin
        if (ir_load) begin
            ir      <= imem_rdata;
            link_pc <= pc + word_t'(1);  // Kept for jal, pc moves in execute
        end
    end

    assign ir_fields = instr_fields_t'(ir);

    control_unit i_control_unit (
        .opcode (ir_fields.opcode),
        .funct  (funct_e'(ir_fields.imm[5:0])),
        .ctrl   (ctrl)
    );

    cycle_fsm i_cycle_fsm (
        .clk, .arst_n, .ctrl, .ir_load, .pc_step, .pc_redirect_en,
        .flag_en, .mem_we, .mem_re, .reg_we
    );

    program_counter #(.RESET_PC(RESET_PC)) i_program_counter (
        .clk, .arst_n,
        .step         (pc_step),
        .redirect_en  (pc_redirect_en),
        .is_jump      (ctrl.is_jump),
        .jump_src_reg (ctrl.jump_src_reg),
        .take_branch, .imm(ir_fields.imm), .rs_data, .pc
    );

    register_file i_register_file (
        .clk, .arst_n,
        .rs_idx (ir_fields.rs),
        .rt_idx (ir_fields.rt),
        .wr_idx, .we(reg_we), .wdata(wb_data), .rs_data, .rt_data
    );

    alu_flags i_alu_flags (
        .clk, .arst_n, .ctrl, .flag_en,
        .a (rs_data), .b_reg(rt_data), .imm(ir_fields.imm),
        .result (alu_result), .take_branch
    );

    always_comb begin
        case (ctrl.wb_sel)
            wb_mem:  wb_data = dmem_rdata;
            wb_pc:   wb_data = link_pc;
            wb_imm:  wb_data = ir_fields.imm;
            default: wb_data = alu_result;
        endcase
        case (ctrl.reg_dst)
            dst_rd:  wr_idx = ir_fields.imm[15:12];  // rd overlays imm top
            dst_r15: wr_idx = reg_idx_t'(15);
            default: wr_idx = ir_fields.rt;
        endcase
    end

    assign imem_addr  = pc;
    assign dmem_addr  = alu_result;  // rs + imm for load and store
    assign dmem_wdata = rt_data;
    assign dmem_we    = mem_we;
    assign dmem_re    = mem_re;

endmodule

`default_nettype wire

// File: tb_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store checker. Watches data memory writes and compares them in order
// with the expected store table built by the testbench top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_checker import cpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  dmem_we,
    input  logic  dmem_re,
    input  word_t dmem_addr,
    input  word_t dmem_wdata,
    input  word_t exp_addr [64],     // Expected stores in program order
    input  word_t exp_data [64],
    input  int    exp_count,
    output int    store_count,
    output int    read_count,
    output int    value_errors,
    output int    order_errors
);

    int n_store = 0;
    int n_read  = 0;
    int n_value = 0;
    int n_order = 0;

    assign store_count  = n_store;
    assign read_count   = n_read;
    assign value_errors = n_value;
    assign order_errors = n_order;

    // Read strobes of all cycles, each load gives exactly one
    always @(negedge clk) begin
        if (dmem_re) begin
            n_read++;
        end
        if (dmem_re && dmem_we) begin
            $display("Data memory read and write strobes high in the same cycle");
            n_order++;
        end
    end

    // Strobe spans a full cycle so the mid-cycle sample sees it once
    always @(negedge clk) begin
        if (dmem_we && !arst_n) begin
            $display("Data memory write strobe seen during reset");
            n_order++;
        end else if (dmem_we) begin
            if (n_store >= exp_count) begin
                $display("Extra store to address %h, only %0d stores expected",
                         dmem_addr, exp_count);
                n_order++;
            end else begin
                if (dmem_addr !== exp_addr[n_store[5:0]]) begin
                    $display("[FAIL] store %0d dmem_addr = %h, expected %h",
                             n_store, dmem_addr, exp_addr[n_store[5:0]]);
                    n_value++;
                end
                if (dmem_wdata !== exp_data[n_store[5:0]]) begin
                    $display("[FAIL] store %0d dmem_wdata = %h, expected %h",
                             n_store, dmem_wdata, exp_data[n_store[5:0]]);
                    n_value++;
                end
            end
            n_store++;
        end
    end

endmodule

`default_nettype wire

// File: tb_cpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top for the multicycle core. Assembles a program from a table
// of test rows, models both memories and decides the verdict
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_cpu import cpu_pkg::*;;

    localparam int    RESET_CYCLES = 16;
    localparam int    HALT_HITS    = 8;         // Four passes of the halt loop
    localparam int    N_ROWS       = 25;
    localparam word_t STORE_BASE   = 16'h0010;  // Presets live below this
    localparam word_t MARK_T       = 16'h0ace;  // Taken path marker
    localparam word_t MARK_NT      = 16'h0bad;
    localparam word_t MARK_CALL    = 16'h0ca1;

    typedef struct packed {
        opcode_e op;
        funct_e  fn;      // ALU rule and flag setter before a branch
        logic    rnd;     // Replace a and b with xorshift values
        word_t   a;
        word_t   b;       // rt value or immediate
    } row_t;

    row_t rows [N_ROWS] = '{
        '{op_r_type, fn_add, 1'b1, 16'h0000, 16'h0000},
        '{op_r_type, fn_sub, 1'b1, 16'h0000, 16'h0000},
        '{op_r_type, fn_and, 1'b1, 16'h0000, 16'h0000},
        '{op_r_type, fn_or,  1'b1, 16'h0000, 16'h0000},
        '{op_r_type, fn_slt, 1'b1, 16'h0000, 16'h0000},
        '{op_r_type, fn_slt, 1'b0, 16'hfff0, 16'h0003},  // -16 < 3
        '{op_r_type, fn_slt, 1'b0, 16'h0005, 16'h8000},  // 5 < -32768 fails
        '{op_addi,   fn_add, 1'b1, 16'h0000, 16'h0000},
        '{op_andi,   fn_and, 1'b1, 16'h0000, 16'h0000},
        '{op_ori,    fn_or,  1'b1, 16'h0000, 16'h0000},
        '{op_slti,   fn_slt, 1'b1, 16'h0000, 16'h0000},
        '{op_slti,   fn_slt, 1'b0, 16'h8000, 16'hffff},  // Both negative
        '{op_load,   fn_add, 1'b0, 16'h0002, 16'h0000},  // a is preset address
        '{op_load,   fn_add, 1'b0, 16'h0007, 16'h0000},
        '{op_loadlit, fn_add, 1'b0, 16'hff80, 16'h0000},
        '{op_beq,    fn_sub, 1'b0, 16'h1234, 16'h1234},
        '{op_beq,    fn_sub, 1'b0, 16'h1234, 16'h1235},
        '{op_bne,    fn_sub, 1'b0, 16'h00ff, 16'h00ff},
        '{op_bne,    fn_sub, 1'b0, 16'h00ff, 16'h0100},
        '{op_jt,     fn_slt, 1'b0, 16'h8001, 16'h0001},
        '{op_jt,     fn_slt, 1'b0, 16'h0010, 16'h0002},
        '{op_jf,     fn_slt, 1'b0, 16'h8001, 16'h0001},
        '{op_jf,     fn_slt, 1'b0, 16'h0010, 16'h0002},
        '{op_j,      fn_add, 1'b0, 16'h0000, 16'h0000},
        '{op_jal,    fn_add, 1'b0, 16'h0000, 16'h0000}
    };

    logic        clk = 1'b0;
    logic        arst_n;
    word_t       imem_addr;
    instr_t      imem_rdata;
    word_t       dmem_addr;
    word_t       dmem_wdata;
    logic        dmem_we;
    logic        dmem_re;
    word_t       dmem_rdata;
    instr_t      rom [256];
    word_t       ram [64];
    word_t       exp_addr [64];
    word_t       exp_data [64];
    int          exp_count = 0;
    int          exp_reads = 0;
    int          n_instr   = 0;
    logic [31:0] rng       = 32'h4b8;
    word_t       ia;                       // Requests seen in the last cycle
    word_t       da;
    word_t       dwd;
    logic        dre;
    logic        dwe;
    int          store_count;
    int          read_count;
    int          value_errors;
    int          order_errors;

    always #2 clk = ~clk;                  // 4 ns period

    cpu_core i_dut (
        .clk, .arst_n, .imem_addr, .imem_rdata,
        .dmem_addr, .dmem_wdata, .dmem_we, .dmem_re, .dmem_rdata
    );

    tb_checker i_checker (
        .clk, .arst_n, .dmem_we, .dmem_re, .dmem_addr, .dmem_wdata,
        .exp_addr, .exp_data, .exp_count,
        .store_count, .read_count, .value_errors, .order_errors
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic instr_t encode(input opcode_e op, input reg_idx_t rs,
                                      input reg_idx_t rt, input word_t imm);
        return {op, rs, rt, 2'b00, imm};
    endfunction

    // Expected ALU result straight from the instruction set rules
    function automatic word_t alu_model(input funct_e fn, input word_t a, input word_t b);
        case (fn)
            fn_sub:  return a - b;
            fn_and:  return a & b;
            fn_or:   return a | b;
            fn_slt:  return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            default: return a + b;
        endcase
    endfunction

    task automatic emit(input instr_t w);
        rom[n_instr[7:0]] = w;
        n_instr++;
    endtask

    // Store register r to the next free slot and record the expected data
    task automatic store_expect(input reg_idx_t r, input word_t data);
        word_t addr;
        addr = STORE_BASE + word_t'(exp_count);
        emit(encode(op_store, 4'd0, r, addr));
        exp_addr[exp_count[5:0]] = addr;
        exp_data[exp_count[5:0]] = data;
        exp_count++;
    endtask

    // Memory models answer 1 ns after the edge that ends the request cycle
    always begin
        @(negedge clk);
        ia  = imem_addr;
        da  = dmem_addr;
        dwd = dmem_wdata;
        dre = dmem_re;
        dwe = dmem_we && arst_n;
        @(posedge clk);
        #1;
        imem_rdata = rom[ia[7:0]];
        if (dwe) begin
            ram[da[5:0]] = dwd;
        end
        if (dre) begin
            dmem_rdata = ram[da[5:0]];
        end
    end

    initial begin
        row_t  r;
        logic  taken;
        word_t l0;
        word_t halt_addr;
        int    cycles;
        int    halt_hits;
        int    limit;
        int    run_errors;
        int    errors;

        arst_n     = 1'b0;
        imem_rdata = '0;
        dmem_rdata = '0;
        run_errors = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i[7:0]] = encode(op_j, 4'd0, 4'd0, word_t'(i));  // Stray fetch loops
        end
        for (int i = 0; i < 64; i++) begin
            ram[i[5:0]] = {10'h2b5, i[5:0]};
        end
        for (int i = 0; i < 8; i++) begin
            rng = xorshift(rng);
            ram[i[5:0]] = rng[15:0];       // Presets for the load rows
        end

        foreach (rows[k]) begin
            r = rows[k];
            if (r.rnd) begin
                rng = xorshift(rng);
                r.a = rng[15:0];
                rng = xorshift(rng);
                r.b = rng[15:0];
            end
            case (r.op)
                op_r_type, op_addi, op_andi, op_ori, op_slti: begin
                    emit(encode(op_loadlit, 4'd0, 4'd1, r.a));
                    if (r.op == op_r_type) begin
                        emit(encode(op_loadlit, 4'd0, 4'd2, r.b));
                        emit(encode(op_r_type, 4'd1, 4'd2, {4'd3, 6'd0, r.fn}));
                    end else begin
                        emit(encode(r.op, 4'd1, 4'd3, r.b));
                    end
                    store_expect(4'd3, alu_model(r.fn, r.a, r.b));
                end
                op_load: begin
                    emit(encode(op_load, 4'd0, 4'd5, r.a));
                    exp_reads++;
                    store_expect(4'd5, ram[r.a[5:0]]);
                end
                op_loadlit: begin
                    emit(encode(op_loadlit, 4'd0, 4'd6, r.a));
                    store_expect(4'd6, r.a);
                end
                op_jal: begin
                    l0 = word_t'(n_instr);
                    emit(encode(op_loadlit, 4'd0, 4'd8, l0 + 16'd3));  // Subroutine
                    emit(encode(op_jal, 4'd8, 4'd0, 16'h0000));
                    emit(encode(op_j, 4'd0, 4'd0, l0 + 16'd6));        // Past it
                    emit(encode(op_loadlit, 4'd0, 4'd9, MARK_CALL));
                    store_expect(4'd9, MARK_CALL);
                    emit(encode(op_r_type, 4'd15, 4'd0, {10'd0, fn_jr}));
                    store_expect(4'd15, l0 + 16'd2);                   // jal address + 1
                end
                default: begin
                    case (r.op)
                        op_beq:  taken = (r.a == r.b);
                        op_bne:  taken = (r.a != r.b);
                        op_jt:   taken = ($signed(r.a) < $signed(r.b));
                        op_jf:   taken = !($signed(r.a) < $signed(r.b));
                        default: taken = 1'b1;                         // j
                    endcase
                    emit(encode(op_loadlit, 4'd0, 4'd1, r.a));
                    emit(encode(op_loadlit, 4'd0, 4'd2, r.b));
                    emit(encode(op_r_type, 4'd1, 4'd2, {4'd3, 6'd0, r.fn}));  // Flags
                    l0 = word_t'(n_instr);
                    if (r.op == op_j) begin
                        emit(encode(op_j, 4'd0, 4'd0, l0 + 16'd3));
                    end else begin
                        emit(encode(r.op, 4'd0, 4'd0, 16'd2));         // To l0+3
                    end
                    emit(encode(op_loadlit, 4'd0, 4'd4, MARK_NT));
                    emit(encode(op_j, 4'd0, 4'd0, l0 + 16'd4));
                    emit(encode(op_loadlit, 4'd0, 4'd4, MARK_T));
                    store_expect(4'd4, taken ? MARK_T : MARK_NT);
                end
            endcase
        end
        halt_addr = word_t'(n_instr);
        emit(encode(op_j, 4'd0, 4'd0, halt_addr));                     // Jump to itself
        limit = 5 * n_instr * 2 + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;

        cycles    = 0;
        halt_hits = 0;
        while (halt_hits < HALT_HITS && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (imem_addr == halt_addr) begin
                halt_hits++;
            end
        end
        if (halt_hits < HALT_HITS) begin
            $display("Timeout, halt loop not reached within %0d cycles", limit);
            run_errors++;
        end
        @(posedge clk);                    // Checker counts settle at negedge
        if (store_count < exp_count) begin
            $display("Missing stores, saw %0d of %0d expected", store_count, exp_count);
            run_errors++;
        end
        if (read_count != exp_reads) begin
            $display("Data memory read strobes seen %0d times, expected %0d",
                     read_count, exp_reads);
            run_errors++;
        end
        errors = value_errors + order_errors + run_errors;
        $display("Errors %0d: value %0d, order %0d, run %0d; stores %0d of %0d",
                 errors, value_errors, order_errors, run_errors, store_count, exp_count);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
cpu_pkg.sv
control_unit.sv
cycle_fsm.sv
program_counter.sv
register_file.sv
alu_flags.sv
cpu_core.sv
tb_checker.sv
tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_cpu
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
PASS_MSG  := === PASS ===

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
